// File: list.f
source/dot_pkg.sv
source/weight_row_stream.sv
source/product_skid_buffer.sv
source/fixed_vector_mult.sv
source/lane_sum_accumulator.sv
source/dot_engine_top.sv
verif/tb_dot_engine.sv

// File: Makefile
# Verilator build and run of the dot-product engine testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module tb_dot_engine -f list.f

# the run passes only if the pass message shows up in the output
run: compile
	@out=$$(./obj_dir/Vtb_dot_engine 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: verif/tb_dot_engine.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dot_engine import dot_pkg::*; ();

  localparam int num_entries = 32;
  // each entry costs a few cycles at most, plus reset, loads and drains
  localparam int cycle_limit = 4 * num_entries + 200;

  logic     clk;
  logic     arst_n;
  act_t     act_vec [lanes];
  logic     act_valid;
  logic     act_ready;
  logic     wload_en;
  row_idx_t wload_row;
  weight_t  wload_vec [lanes];
  acc_t     result;
  logic     result_valid;
  logic     result_ready;

  // stimulus table, one activation vector per entry
  act_t     tab_act [num_entries][lanes];
  logic     tab_gap [num_entries];
  int       tab_stall [num_entries];

  // reference model state
  weight_t  w_model [rows][lanes];
  int       model_sum = 0;
  int       model_row = 0;
  acc_t     exp_q [$];
  int       stall_q [$];
  int       results_seen = 0;
  int       cycle_cnt = 0;
  integer   seed = 32'h9ae4_6206;

  dot_engine_top UUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .act_vec      (act_vec),
    .act_valid    (act_valid),
    .act_ready    (act_ready),
    .wload_en     (wload_en),
    .wload_row    (wload_row),
    .wload_vec    (wload_vec),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

  always #20 clk = ~clk;

  task automatic report_failure();
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic compare_acc(input acc_t actual, input acc_t expected, input string what);
    if (actual !== expected) begin
      $display("Fail at %0t: %s expected %0d, got %0d", $time, what, expected, actual);
      report_failure();
    end
  endtask

  task automatic compare_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("Fail at %0t: %s expected %b, got %b", $time, what, expected, actual);
      report_failure();
    end
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    for (int i = 0; i < num_entries; i++) begin
      tab_gap[i]   = 1'b0;
      tab_stall[i] = 0;
      for (int l = 0; l < lanes; l++) begin
        if (i < 8) begin
          tab_act[i][l] = act_t'(i % rows + l + 1);
        end else if (i < 12) begin
          tab_act[i][l] = act_t'(-128);
        end else if (i < 16) begin
          tab_act[i][l] = (l % 2 == 0) ? act_t'(127) : act_t'(-128);
        end else begin
          rnd = $random(seed);
          tab_act[i][l] = act_t'(rnd[7:0]);
        end
      end
      if (i >= 16) begin
        rnd = $random(seed);
        tab_gap[i]   = rnd[4];
        tab_stall[i] = int'(rnd[9:8]);
      end
    end
    // hand-placed gaps and result stalls in the directed groups
    tab_gap[2]    = 1'b1;
    tab_gap[5]    = 1'b1;
    tab_gap[9]    = 1'b1;
    tab_stall[3]  = 2;
    tab_stall[11] = 1;
    tab_stall[15] = 3;
  endtask

  // mode 0 small positive, 1 extreme values, else random
  task automatic load_weights(input int mode);
    logic [31:0] rnd;
    weight_t     w;
    for (int r = 0; r < rows; r++) begin
      for (int l = 0; l < lanes; l++) begin
        case (mode)
          0: w = weight_t'(r * lanes + l + 1);
          1: w = (r == rows - 1) ? weight_t'(127) : weight_t'(-128);
          default: begin
            rnd = $random(seed);
            w   = weight_t'(rnd[15:8]);
          end
        endcase
        w_model[r][l] = w;
        wload_vec[l] <= w;
      end
      wload_row <= row_idx_t'(r);
      wload_en  <= 1'b1;
      @(posedge clk);
    end
    wload_en <= 1'b0;
    @(posedge clk);
  endtask

  // one accepted activation, paired with the next weight row in order
  task automatic model_beat(input int idx);
    for (int l = 0; l < lanes; l++) begin
      model_sum += int'(tab_act[idx][l]) * int'(w_model[model_row][l]);
    end
    if (model_row == rows - 1) begin
      exp_q.push_back(acc_t'(model_sum));
      stall_q.push_back(tab_stall[idx]);
      model_sum = 0;
      model_row = 0;
    end else begin
      model_row++;
    end
  endtask

  task automatic apply_entries(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      if (tab_gap[i]) begin
        act_valid <= 1'b0;
        @(posedge clk);
      end
      for (int l = 0; l < lanes; l++) begin
        act_vec[l] <= tab_act[i][l];
      end
      act_valid <= 1'b1;
      @(posedge clk);
      while (!act_ready) begin
        @(posedge clk);
      end
      model_beat(i);
    end
    act_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  initial begin : main_flow
    int n;
    build_table();
    clk          = 1'b0;
    arst_n       = 1'b0;
    act_valid    = 1'b0;
    wload_en     = 1'b0;
    wload_row    = '0;
    result_ready = 1'b0;
    for (int l = 0; l < lanes; l++) begin
      act_vec[l]   = '0;
      wload_vec[l] = '0;
    end
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    compare_bit(result_valid, 1'b0, "result_valid after reset");
    n = 0;
    while (!act_ready && n < 4) begin
      @(posedge clk);
      n++;
    end
    if (!act_ready) begin
      $display("act_ready did not rise within a few cycles after reset");
      report_failure();
    end

    load_weights(0);
    apply_entries(0, 7);
    wait_drained();
    // new weights must show up in the next groups
    load_weights(1);
    apply_entries(8, 15);
    wait_drained();
    load_weights(2);
    apply_entries(16, num_entries - 1);
    wait_drained();
    repeat (4) @(posedge clk);

    if (exp_q.size() == 0 && !result_valid) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("results still pending or extra result at the end of the run");
      report_failure();
    end
  end

  // result side: hold ready low for the group's stall count, then take one result
  initial begin : result_side
    int stall;
    forever begin
      @(posedge clk);
      if (arst_n && result_valid) begin
        stall = (stall_q.size() != 0) ? stall_q.pop_front() : 0;
        repeat (stall) @(posedge clk);
        result_ready <= 1'b1;
        @(posedge clk);
        if (exp_q.size() == 0) begin
          $display("result transfer with no result expected");
          report_failure();
        end else begin
          result_ready <= 1'b0;
          compare_acc(result, exp_q.pop_front(), $sformatf("result %0d", results_seen));
          results_seen++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: test did not finish within %0d clock cycles", cycle_limit);
      report_failure();
    end
  end

endmodule : tb_dot_engine

`default_nettype wire

// File: source/dot_engine_top.sv
`timescale 1ns/10ps
`default_nettype none

module dot_engine_top import dot_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,

  // activation stream
  input  act_t     act_vec [lanes],
  input  logic     act_valid,
  output logic     act_ready,

  // weight load port
  input  logic     wload_en,
  input  row_idx_t wload_row,
  input  weight_t  wload_vec [lanes],

  // dot product output
  output acc_t     result,
  output logic     result_valid,
  input  logic     result_ready
);

  // weight stream
  weight_t w_vec [lanes];
  logic    w_last;
  logic    w_valid;
  logic    w_ready;

  // product stream
  prod_t   p_vec [lanes];
  logic    p_last;
  logic    p_valid;
  logic    p_ready;

  weight_row_stream u_weights (
    .clk       (clk),
    .arst_n    (arst_n),
    .wload_en  (wload_en),
    .wload_row (wload_row),
    .wload_vec (wload_vec),
    .w_vec     (w_vec),
    .w_last    (w_last),
    .w_valid   (w_valid),
    .w_ready   (w_ready)
  );

  fixed_vector_mult u_mult (
    .clk       (clk),
    .arst_n    (arst_n),
    .act_vec   (act_vec),
    .act_valid (act_valid),
    .act_ready (act_ready),
    .w_vec     (w_vec),
    .w_last    (w_last),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .p_vec     (p_vec),
    .p_last    (p_last),
    .p_valid   (p_valid),
    .p_ready   (p_ready)
  );

  lane_sum_accumulator u_acc (
    .clk          (clk),
    .arst_n       (arst_n),
    .p_vec        (p_vec),
    .p_last       (p_last),
    .p_valid      (p_valid),
    .p_ready      (p_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

endmodule : dot_engine_top

`default_nettype wire

// File: source/lane_sum_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module lane_sum_accumulator import dot_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,

  // product stream
  input  prod_t p_vec [lanes],
  input  logic  p_last,
  input  logic  p_valid,
  output logic  p_ready,

  // one dot product per group
  output acc_t  result,
  output logic  result_valid,
  input  logic  result_ready
);

  acc_state_e state;
  acc_state_e state_d;
  acc_t       lane_ext [lanes];
  acc_t       pair_sum [lanes/2];
  acc_t       beat_sum;
  acc_t       total;
  acc_t       result_q;
  logic       beat_xfer;
  logic       res_xfer;

  // sign-extend every lane before adding
  for (genvar i = 0; i < lanes; i++) begin : g_ext
    assign lane_ext[i] = acc_t'(p_vec[i]);
  end

  // two-level adder tree
  for (genvar j = 0; j < lanes/2; j++) begin : g_pair
    assign pair_sum[j] = lane_ext[2*j] + lane_ext[2*j+1];
  end
  assign beat_sum = pair_sum[0] + pair_sum[1];

  assign result_valid = (state == hold_result);
  assign result       = result_q;

  // hold the product stream only while a result is stuck at the output
  assign p_ready   = !result_valid || result_ready;
  assign beat_xfer = p_valid && p_ready;
  assign res_xfer  = result_valid && result_ready;

  always_comb begin
    state_d = state;
    case (state)
      idle_sum: begin
        if (beat_xfer && p_last) begin
          state_d = hold_result;
        end
      end
      hold_result: begin
        // a last beat in the same cycle reloads the result
        if (res_xfer && !(beat_xfer && p_last)) begin
          state_d = idle_sum;
        end
      end
      default: state_d = idle_sum;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= idle_sum;
      total    <= '0;
      result_q <= '0;
    end else begin
      state <= state_d;
      if (beat_xfer) begin
        if (p_last) begin
          result_q <= total + beat_sum;
          total    <= '0;
        end else begin
          total <= total + beat_sum;
        end
      end
    end
  end

  a_result_held : assert property (@(posedge clk) disable iff (!arst_n)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else $error("result dropped or changed before transfer");

endmodule : lane_sum_accumulator

`default_nettype wire

// File: source/fixed_vector_mult.sv
`timescale 1ns/10ps
`default_nettype none

module fixed_vector_mult import dot_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,

  // activation input
  input  act_t    act_vec [lanes],
  input  logic    act_valid,
  output logic    act_ready,

  // weight row input
  input  weight_t w_vec [lanes],
  input  logic    w_last,
  input  logic    w_valid,
  output logic    w_ready,

  // registered product output
  output prod_t   p_vec [lanes],
  output logic    p_last,
  output logic    p_valid,
  input  logic    p_ready
);

  prod_t prod_vec [lanes];
  logic  pair_valid;
  logic  buf_ready;

  // a pair moves only when both sides are valid and the buffer has room
  assign pair_valid = act_valid && w_valid;
  assign act_ready  = w_valid && buf_ready;
  assign w_ready    = act_valid && buf_ready;

  // signed lane products at full width so nothing is lost
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    assign prod_vec[i] = act_vec[i] * w_vec[i];
  end

  // the row's last flag rides along with its product
  product_skid_buffer u_skid (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_vec    (prod_vec),
    .in_last   (w_last),
    .in_valid  (pair_valid),
    .in_ready  (buf_ready),
    .out_vec   (p_vec),
    .out_last  (p_last),
    .out_valid (p_valid),
    .out_ready (p_ready)
  );

endmodule : fixed_vector_mult

`default_nettype wire

// File: source/product_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module product_skid_buffer import dot_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,

  input  prod_t in_vec [lanes],
  input  logic  in_last,
  input  logic  in_valid,
  output logic  in_ready,

  output prod_t out_vec [lanes],
  output logic  out_last,
  output logic  out_valid,
  input  logic  out_ready
);

  // main entry drives the output, skid catches a beat during a stall
  prod_t main_vec [lanes];
  prod_t skid_vec [lanes];
  logic  main_last;
  logic  skid_last;
  logic  main_valid;
  logic  skid_valid;
  logic  main_valid_d;
  logic  skid_valid_d;
  logic  ready_q;
  logic  in_xfer;
  logic  load_main_in;
  logic  load_main_skid;
  logic  load_skid;

  assign in_xfer = in_valid && ready_q;

  always_comb begin
    main_valid_d   = main_valid;
    skid_valid_d   = skid_valid;
    load_main_in   = 1'b0;
    load_main_skid = 1'b0;
    load_skid      = 1'b0;
    if (skid_valid) begin
      // both full, drain the skid entry into main
      if (out_ready) begin
        load_main_skid = 1'b1;
        skid_valid_d   = 1'b0;
      end
    end else if (in_xfer) begin
      if (!main_valid || out_ready) begin
        load_main_in = 1'b1;
        main_valid_d = 1'b1;
      end else begin
        load_skid    = 1'b1;
        skid_valid_d = 1'b1;
      end
    end else if (out_ready) begin
      main_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      main_valid <= main_valid_d;
      skid_valid <= skid_valid_d;
      // ready is a flop so out_ready never reaches in_ready combinationally
      ready_q    <= !skid_valid_d;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (load_main_in) begin
      main_vec  <= in_vec;
      main_last <= in_last;
    end else if (load_main_skid) begin
      main_vec  <= skid_vec;
      main_last <= skid_last;
    end
    if (load_skid) begin
      skid_vec  <= in_vec;
      skid_last <= in_last;
    end
  end

  assign in_ready  = ready_q;
  assign out_vec   = main_vec;
  assign out_last  = main_last;
  assign out_valid = main_valid;

  a_full_not_ready : assert property (@(posedge clk) disable iff (!arst_n)
    main_valid && skid_valid |-> !in_ready)
    else $error("skid buffer ready while both entries are full");

  a_last_stable : assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_last))
    else $error("output dropped or changed while stalled");

  for (genvar i = 0; i < lanes; i++) begin : g_lane_chk
    a_vec_stable : assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> $stable(out_vec[i]))
      else $error("product lane changed while stalled");
  end

endmodule : product_skid_buffer

`default_nettype wire

// File: source/weight_row_stream.sv
`timescale 1ns/10ps
`default_nettype none

module weight_row_stream import dot_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,

  // write-only load port
  input  logic     wload_en,
  input  row_idx_t wload_row,
  input  weight_t  wload_vec [lanes],

  // weight row stream
  output weight_t  w_vec [lanes],
  output logic     w_last,
  output logic     w_valid,
  input  logic     w_ready
);

  // weight matrix, one vector per row
  weight_t  w_mem [rows][lanes];
  row_idx_t row_ptr;
  logic     valid_q;
  logic     w_xfer;

  assign w_xfer = w_valid && w_ready;

  // loads land at the edge, no handshake
  always_ff @(posedge clk) begin
    if (wload_en) begin
      w_mem[wload_row] <= wload_vec;
    end
  end

  // row pointer steps on every transfer and wraps after the last row
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      row_ptr <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      if (w_xfer) begin
        if (row_ptr == row_idx_t'(rows - 1)) begin
          row_ptr <= '0;
        end else begin
          row_ptr <= row_ptr + 1'b1;
        end
      end
    end
  end

  assign w_vec   = w_mem[row_ptr];
  assign w_last  = (row_ptr == row_idx_t'(rows - 1));
  assign w_valid = valid_q;

  // a row must not be rewritten in the cycle it is consumed downstream
  a_no_load_on_live_row : assert property (@(posedge clk) disable iff (!arst_n)
    !(wload_en && w_xfer && (wload_row == row_ptr)))
    else $error("weight load hit the row being transferred");

endmodule : weight_row_stream

`default_nettype wire

// File: source/dot_pkg.sv
`default_nettype none

package dot_pkg;

  // vector geometry
  localparam int lanes = 4;
  localparam int rows  = 4;

  // element widths
  localparam int act_width    = 8;
  localparam int weight_width = 8;
  localparam int prod_width   = act_width + weight_width;

  // four guard bits cover rows * lanes = 16 summed products
  localparam int acc_width     = prod_width + 4;
  localparam int row_idx_width = 2;

  // signed element types
  typedef logic signed [act_width-1:0]    act_t;
  typedef logic signed [weight_width-1:0] weight_t;
  typedef logic signed [prod_width-1:0]   prod_t;
  typedef logic signed [acc_width-1:0]    acc_t;

  // weight row address
  typedef logic [row_idx_width-1:0] row_idx_t;

  // accumulator control
  typedef enum logic {
    idle_sum,
    hold_result
  } acc_state_e;

endpackage : dot_pkg

`default_nettype wire
